// ==== design/queue_pkg.sv ====
package queue_pkg;

    typedef logic [63:0] flit_data_t;
    typedef logic [15:0] flit_dest_t;
    typedef logic [127:0] mem_word_t; // one ring slot.
    typedef logic [31:0] addr_t;      // word address.
    typedef logic [15:0] ptr_t;       // ring index, capacity too.

    // data sits in the low bits, dest above it, last flag on top.
    localparam int LAST_BIT = 80;

    function automatic mem_word_t pack_flit(
        input flit_data_t data,
        input flit_dest_t dest,
        input logic last
    );
        mem_word_t word;
        word = '0; // unused upper bits stay zero.
        word[LAST_BIT:0] = {last, dest, data};
        return word;
    endfunction

endpackage

// ==== design/cfg_pkg.sv ====
package cfg_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // low bits pick the register, the rest pick the queue.
    localparam int QUEUE_LSB = 3;

    localparam logic [2:0] REG_CTRL = 3'd0;
    localparam logic [2:0] REG_BASE = 3'd1;
    localparam logic [2:0] REG_CAPACITY = 3'd2;
    localparam logic [2:0] REG_HOST_PTR = 3'd3;
    localparam logic [2:0] REG_DEV_PTR = 3'd4;
    localparam logic [2:0] REG_STATUS = 3'd5;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_RESET_BIT = 1; // self clearing.
    localparam int STATUS_IDLE_BIT = 0;

endpackage

// ==== design/cfg_regs.sv ====
module cfg_regs #(
    parameter int NUM_QUEUES = 2
) (
    input logic clk,
    input logic rst,

    input logic cfg_wr,
    input logic cfg_rd,
    input cfg_pkg::reg_addr_t cfg_addr,
    input cfg_pkg::reg_data_t cfg_wdata,
    output cfg_pkg::reg_data_t cfg_rdata,
    output logic cfg_rdata_valid,

    input queue_pkg::ptr_t [NUM_QUEUES-1:0] status_dev_ptr,
    input logic [NUM_QUEUES-1:0] status_idle,

    output logic [NUM_QUEUES-1:0] cfg_enable,
    output logic [NUM_QUEUES-1:0] cfg_reset,
    output queue_pkg::addr_t [NUM_QUEUES-1:0] cfg_base_addr,
    output queue_pkg::ptr_t [NUM_QUEUES-1:0] cfg_capacity,
    output queue_pkg::ptr_t [NUM_QUEUES-1:0] cfg_host_ptr
);

    logic [4:0] sel_queue;
    logic [2:0] sel_reg;
    cfg_pkg::reg_data_t rd_word;

    assign sel_queue = cfg_addr[7:cfg_pkg::QUEUE_LSB];
    assign sel_reg = cfg_addr[cfg_pkg::QUEUE_LSB-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_enable <= '0;
            cfg_reset <= '0;
            cfg_base_addr <= '0;
            cfg_capacity <= '0;
            cfg_host_ptr <= '0;
        end else begin
            cfg_reset <= '0; // one cycle pulse.
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (cfg_wr && sel_queue == q) begin
                    case (sel_reg)
                        cfg_pkg::REG_CTRL: begin
                            cfg_enable[q] <= cfg_wdata[cfg_pkg::CTRL_ENABLE_BIT];
                            cfg_reset[q] <= cfg_wdata[cfg_pkg::CTRL_RESET_BIT];
                        end
                        cfg_pkg::REG_BASE: cfg_base_addr[q] <= cfg_wdata;
                        cfg_pkg::REG_CAPACITY: cfg_capacity[q] <= cfg_wdata[15:0];
                        cfg_pkg::REG_HOST_PTR: cfg_host_ptr[q] <= cfg_wdata[15:0];
                        default: ; // dev ptr and status are read only.
                    endcase
                end
            end
        end
    end

    // unmapped queues and offsets fall through as zero.
    always_comb begin
        rd_word = '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (sel_queue == q) begin
                case (sel_reg)
                    cfg_pkg::REG_CTRL: rd_word[cfg_pkg::CTRL_ENABLE_BIT] = cfg_enable[q];
                    cfg_pkg::REG_BASE: rd_word = cfg_base_addr[q];
                    cfg_pkg::REG_CAPACITY: rd_word[15:0] = cfg_capacity[q];
                    cfg_pkg::REG_HOST_PTR: rd_word[15:0] = cfg_host_ptr[q];
                    cfg_pkg::REG_DEV_PTR: rd_word[15:0] = status_dev_ptr[q];
                    cfg_pkg::REG_STATUS: rd_word[cfg_pkg::STATUS_IDLE_BIT] = status_idle[q];
                    default: rd_word = '0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_rdata_valid <= 1'b0;
        end else begin
            cfg_rdata_valid <= cfg_rd;
        end
    end

    always_ff @(posedge clk) begin
        cfg_rdata <= rd_word;
    end

    // the bus master issues one access per cycle.
    assert property (@(posedge clk) disable iff (rst) !(cfg_rd && cfg_wr))
        else $error("cfg read and write in the same cycle");

    assert property (@(posedge clk) disable iff (rst) (cfg_reset & $past(cfg_reset)) == '0)
        else $error("queue reset held longer than one cycle");

endmodule

// ==== design/tx_queue.sv ====
module tx_queue (
    input logic clk,
    input logic rst,

    input logic cfg_enable,
    input logic cfg_reset,
    input queue_pkg::addr_t cfg_base_addr,
    input queue_pkg::ptr_t cfg_capacity,
    input queue_pkg::ptr_t cfg_host_ptr,
    output queue_pkg::ptr_t status_dev_ptr,
    output logic status_idle,

    input queue_pkg::flit_data_t data,
    input queue_pkg::flit_dest_t dest,
    input logic last,
    input logic valid,
    output logic ready,

    output logic req_valid,
    input logic req_ready,
    output logic req_write,
    output queue_pkg::addr_t req_addr,
    output queue_pkg::mem_word_t req_wdata,
    input logic rsp_valid,
    input queue_pkg::mem_word_t rsp_rdata
);

    typedef enum logic {ST_IDLE, ST_WRITE} state_t;

    state_t state;
    queue_pkg::ptr_t dev_ptr;  // ring tail.
    queue_pkg::ptr_t next_ptr;
    queue_pkg::mem_word_t word_q;
    logic full;

    assign next_ptr = (dev_ptr + 16'd1 == cfg_capacity) ? '0 : dev_ptr + 16'd1;
    assign full = next_ptr == cfg_host_ptr; // one slot kept empty.

    assign ready = cfg_enable && state == ST_IDLE && !full;
    assign req_valid = state == ST_WRITE;
    assign req_write = 1'b1;
    assign req_addr = cfg_base_addr + queue_pkg::addr_t'(dev_ptr);
    assign req_wdata = word_q;
    assign status_dev_ptr = dev_ptr;
    assign status_idle = state == ST_IDLE;

    always_ff @(posedge clk) begin
        if (rst || cfg_reset) begin
            state <= ST_IDLE;
            dev_ptr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (valid && ready) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (req_ready) begin
                        dev_ptr <= next_ptr; // write done at acceptance.
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (valid && ready) begin
            word_q <= queue_pkg::pack_flit(data, dest, last);
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready && !cfg_reset |=> req_valid)
        else $error("tx write request dropped before acceptance");

    // only rx engines read, so the arbiter never routes data here.
    assert property (@(posedge clk) disable iff (rst) !rsp_valid)
        else $error("tx engine got read data %h", rsp_rdata);

endmodule

// ==== design/rx_queue.sv ====
module rx_queue (
    input logic clk,
    input logic rst,

    input logic cfg_enable,
    input logic cfg_reset,
    input queue_pkg::addr_t cfg_base_addr,
    input queue_pkg::ptr_t cfg_capacity,
    input queue_pkg::ptr_t cfg_host_ptr,
    output queue_pkg::ptr_t status_dev_ptr,
    output logic status_idle,

    output queue_pkg::flit_data_t data,
    output queue_pkg::flit_dest_t dest,
    output logic last,
    output logic valid,
    input logic ready,

    output logic req_valid,
    input logic req_ready,
    output logic req_write,
    output queue_pkg::addr_t req_addr,
    output queue_pkg::mem_word_t req_wdata,
    input logic rsp_valid,
    input queue_pkg::mem_word_t rsp_rdata
);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_PRESENT} state_t;

    state_t state;
    queue_pkg::ptr_t dev_ptr;  // ring head.
    queue_pkg::ptr_t next_ptr;
    logic issued;    // read accepted, data not back yet.
    logic discard;   // stale read still in flight.
    logic in_flight;

    assign next_ptr = (dev_ptr + 16'd1 == cfg_capacity) ? '0 : dev_ptr + 16'd1;

    assign req_valid = state == ST_READ && !issued;
    assign req_write = 1'b0;
    assign req_addr = cfg_base_addr + queue_pkg::addr_t'(dev_ptr);
    assign req_wdata = '0;
    assign valid = state == ST_PRESENT;
    assign status_dev_ptr = dev_ptr;
    assign status_idle = state == ST_IDLE;

    // read that still owes a response after this cycle.
    assign in_flight = state == ST_READ && (issued ? !rsp_valid : req_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            dev_ptr <= '0;
            issued <= 1'b0;
            discard <= 1'b0;
        end else if (cfg_reset) begin
            state <= ST_IDLE;
            dev_ptr <= '0;
            issued <= 1'b0;
            discard <= (discard && !rsp_valid) || in_flight;
        end else begin
            if (discard && rsp_valid) begin
                discard <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (cfg_enable && !discard && dev_ptr != cfg_host_ptr) begin
                        state <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (req_valid && req_ready) begin
                        issued <= 1'b1;
                    end
                    if (issued && rsp_valid) begin
                        issued <= 1'b0;
                        state <= ST_PRESENT;
                    end
                end
                ST_PRESENT: begin
                    if (ready) begin
                        dev_ptr <= next_ptr;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // flit held until the stream takes it.
    always_ff @(posedge clk) begin
        if (state == ST_READ && issued && rsp_valid) begin
            {last, dest, data} <= rsp_rdata[queue_pkg::LAST_BIT:0];
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> (state == ST_READ && issued) || discard)
        else $error("rx engine got a response it did not ask for");

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter #(
    parameter int NUM_PORTS = 2,
    parameter int TAG_WIDTH = 1
) (
    input logic clk,
    input logic rst,

    input logic [NUM_PORTS-1:0] req_valid,
    output logic [NUM_PORTS-1:0] req_ready,
    input logic [NUM_PORTS-1:0] req_write,
    input queue_pkg::addr_t [NUM_PORTS-1:0] req_addr,
    input queue_pkg::mem_word_t [NUM_PORTS-1:0] req_wdata,
    output logic [NUM_PORTS-1:0] rsp_valid,
    output queue_pkg::mem_word_t [NUM_PORTS-1:0] rsp_rdata,

    output logic mem_req_valid,
    input logic mem_req_ready,
    output logic mem_req_write,
    output queue_pkg::addr_t mem_req_addr,
    output queue_pkg::mem_word_t mem_req_wdata,
    output logic [TAG_WIDTH-1:0] mem_req_tag,
    input logic mem_rsp_valid,
    input logic [TAG_WIDTH-1:0] mem_rsp_tag,
    input queue_pkg::mem_word_t mem_rsp_rdata
);

    logic [TAG_WIDTH-1:0] rr_ptr; // first port to look at.
    logic [TAG_WIDTH-1:0] grant;
    logic found;

    always_comb begin
        int cand;
        found = 1'b0;
        grant = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            cand = (int'(rr_ptr) + k) % NUM_PORTS;
            if (!found && req_valid[cand]) begin
                found = 1'b1;
                grant = TAG_WIDTH'(cand);
            end
        end
    end

    // tag carries the port index so the read data finds its way back.
    assign mem_req_valid = found;
    assign mem_req_write = req_write[grant];
    assign mem_req_addr = req_addr[grant];
    assign mem_req_wdata = req_wdata[grant];
    assign mem_req_tag = grant;

    always_comb begin
        req_ready = '0;
        req_ready[grant] = found && mem_req_ready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (mem_req_valid && mem_req_ready) begin
            rr_ptr <= (int'(grant) == NUM_PORTS - 1) ? '0 : grant + 1'b1;
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rsp_valid[p] = mem_rsp_valid && int'(mem_rsp_tag) == p;
            rsp_rdata[p] = mem_rsp_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(req_ready))
        else $error("more than one port granted");

    assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> int'(mem_rsp_tag) < NUM_PORTS)
        else $error("response tag %0d names no port", mem_rsp_tag);

endmodule

// ==== design/fpga_queues.sv ====
module fpga_queues #(
    parameter int NUM_RX_QUEUES = 1,
    parameter int NUM_TX_QUEUES = 1,
    localparam int NUM_QUEUES = NUM_RX_QUEUES + NUM_TX_QUEUES,
    localparam int TAG_WIDTH = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1
) (
    input logic clk,
    input logic rst,

    input logic cfg_wr,
    input logic cfg_rd,
    input cfg_pkg::reg_addr_t cfg_addr,
    input cfg_pkg::reg_data_t cfg_wdata,
    output cfg_pkg::reg_data_t cfg_rdata,
    output logic cfg_rdata_valid,

    output queue_pkg::flit_data_t [NUM_RX_QUEUES-1:0] rx_data,
    output queue_pkg::flit_dest_t [NUM_RX_QUEUES-1:0] rx_dest,
    output logic [NUM_RX_QUEUES-1:0] rx_last,
    output logic [NUM_RX_QUEUES-1:0] rx_valid,
    input logic [NUM_RX_QUEUES-1:0] rx_ready,

    input queue_pkg::flit_data_t [NUM_TX_QUEUES-1:0] tx_data,
    input queue_pkg::flit_dest_t [NUM_TX_QUEUES-1:0] tx_dest,
    input logic [NUM_TX_QUEUES-1:0] tx_last,
    input logic [NUM_TX_QUEUES-1:0] tx_valid,
    output logic [NUM_TX_QUEUES-1:0] tx_ready,

    output logic mem_req_valid,
    input logic mem_req_ready,
    output logic mem_req_write,
    output queue_pkg::addr_t mem_req_addr,
    output queue_pkg::mem_word_t mem_req_wdata,
    output logic [TAG_WIDTH-1:0] mem_req_tag,
    input logic mem_rsp_valid,
    input logic [TAG_WIDTH-1:0] mem_rsp_tag,
    input queue_pkg::mem_word_t mem_rsp_rdata
);

    logic [NUM_QUEUES-1:0] cfg_enable;
    logic [NUM_QUEUES-1:0] cfg_reset;
    queue_pkg::addr_t [NUM_QUEUES-1:0] cfg_base_addr;
    queue_pkg::ptr_t [NUM_QUEUES-1:0] cfg_capacity;
    queue_pkg::ptr_t [NUM_QUEUES-1:0] cfg_host_ptr;
    queue_pkg::ptr_t [NUM_QUEUES-1:0] status_dev_ptr;
    logic [NUM_QUEUES-1:0] status_idle;

    // one request and response slot per engine, rx first.
    logic [NUM_QUEUES-1:0] req_valid;
    logic [NUM_QUEUES-1:0] req_ready;
    logic [NUM_QUEUES-1:0] req_write;
    queue_pkg::addr_t [NUM_QUEUES-1:0] req_addr;
    queue_pkg::mem_word_t [NUM_QUEUES-1:0] req_wdata;
    logic [NUM_QUEUES-1:0] rsp_valid;
    queue_pkg::mem_word_t [NUM_QUEUES-1:0] rsp_rdata;

    for (genvar i = 0; i < NUM_RX_QUEUES; i++) begin : g_rx
        rx_queue rx (
            .clk, .rst,
            .cfg_enable(cfg_enable[i]), .cfg_reset(cfg_reset[i]),
            .cfg_base_addr(cfg_base_addr[i]), .cfg_capacity(cfg_capacity[i]),
            .cfg_host_ptr(cfg_host_ptr[i]),
            .status_dev_ptr(status_dev_ptr[i]), .status_idle(status_idle[i]),
            .data(rx_data[i]), .dest(rx_dest[i]), .last(rx_last[i]),
            .valid(rx_valid[i]), .ready(rx_ready[i]),
            .req_valid(req_valid[i]), .req_ready(req_ready[i]),
            .req_write(req_write[i]), .req_addr(req_addr[i]), .req_wdata(req_wdata[i]),
            .rsp_valid(rsp_valid[i]), .rsp_rdata(rsp_rdata[i])
        );
    end

    for (genvar i = NUM_RX_QUEUES; i < NUM_QUEUES; i++) begin : g_tx
        tx_queue tx (
            .clk, .rst,
            .cfg_enable(cfg_enable[i]), .cfg_reset(cfg_reset[i]),
            .cfg_base_addr(cfg_base_addr[i]), .cfg_capacity(cfg_capacity[i]),
            .cfg_host_ptr(cfg_host_ptr[i]),
            .status_dev_ptr(status_dev_ptr[i]), .status_idle(status_idle[i]),
            .data(tx_data[i-NUM_RX_QUEUES]), .dest(tx_dest[i-NUM_RX_QUEUES]),
            .last(tx_last[i-NUM_RX_QUEUES]),
            .valid(tx_valid[i-NUM_RX_QUEUES]), .ready(tx_ready[i-NUM_RX_QUEUES]),
            .req_valid(req_valid[i]), .req_ready(req_ready[i]),
            .req_write(req_write[i]), .req_addr(req_addr[i]), .req_wdata(req_wdata[i]),
            .rsp_valid(rsp_valid[i]), .rsp_rdata(rsp_rdata[i])
        );
    end

    cfg_regs #(
        .NUM_QUEUES(NUM_QUEUES)
    ) regs (
        .clk, .rst,
        .cfg_wr, .cfg_rd, .cfg_addr, .cfg_wdata, .cfg_rdata, .cfg_rdata_valid,
        .status_dev_ptr, .status_idle,
        .cfg_enable, .cfg_reset, .cfg_base_addr, .cfg_capacity, .cfg_host_ptr
    );

    mem_arbiter #(
        .NUM_PORTS(NUM_QUEUES),
        .TAG_WIDTH(TAG_WIDTH)
    ) arbiter (
        .clk, .rst,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .rsp_valid, .rsp_rdata,
        .mem_req_valid, .mem_req_ready, .mem_req_write,
        .mem_req_addr, .mem_req_wdata, .mem_req_tag,
        .mem_rsp_valid, .mem_rsp_tag, .mem_rsp_rdata
    );

endmodule

// ==== tests/tb_mem_model.sv ====
module tb_mem_model #(
    parameter int TAG_WIDTH = 1,
    parameter int DEPTH = 512
) (
    input logic clk,
    input logic rst,

    input logic mem_req_valid,
    output logic mem_req_ready,
    input logic mem_req_write,
    input queue_pkg::addr_t mem_req_addr,
    input queue_pkg::mem_word_t mem_req_wdata,
    input logic [TAG_WIDTH-1:0] mem_req_tag,
    output logic mem_rsp_valid,
    output logic [TAG_WIDTH-1:0] mem_rsp_tag,
    output queue_pkg::mem_word_t mem_rsp_rdata
);

    localparam int AW = $clog2(DEPTH);

    queue_pkg::mem_word_t mem [DEPTH];
    integer seed = 78;
    int now_cycle = 0;
    int due_q[$];                      // pending reads, oldest first.
    logic [TAG_WIDTH-1:0] tag_q[$];
    queue_pkg::mem_word_t data_q[$];

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_tag = '0;
        mem_rsp_rdata = '0;
    end

    always @(posedge clk) begin
        int due;
        now_cycle = now_cycle + 1;
        mem_req_ready <= !rst && (($random(seed) & 3) != 0);
        mem_rsp_valid <= 1'b0;
        if (!rst && mem_req_valid && mem_req_ready) begin
            if (mem_req_write) begin
                mem[mem_req_addr[AW-1:0]] = mem_req_wdata;
            end else begin
                due = now_cycle + 1 + ($random(seed) & 3);
                if (due_q.size() > 0 && due <= due_q[$]) begin
                    due = due_q[$] + 1; // in order, one per cycle.
                end
                due_q.push_back(due);
                tag_q.push_back(mem_req_tag);
                data_q.push_back(mem[mem_req_addr[AW-1:0]]);
            end
        end
        if (due_q.size() > 0 && due_q[0] <= now_cycle) begin
            mem_rsp_valid <= 1'b1;
            mem_rsp_tag <= tag_q.pop_front();
            mem_rsp_rdata <= data_q.pop_front();
            void'(due_q.pop_front());
        end
    end

endmodule

// ==== tests/tb_fpga_queues.sv ====
module tb_fpga_queues;

    localparam int RX_Q = 0;
    localparam int TX_Q = 1;
    localparam int CAP = 8;
    localparam int RX_BASE = 'h40;
    localparam int TX_BASE = 'h100;
    localparam int TIMEOUT = 2000;
    localparam logic [31:0] CTRL_ON = 32'd1 << cfg_pkg::CTRL_ENABLE_BIT;
    localparam logic [31:0] CTRL_RESET = CTRL_ON | (32'd1 << cfg_pkg::CTRL_RESET_BIT);

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic cfg_wr = 1'b0;
    logic cfg_rd = 1'b0;
    cfg_pkg::reg_addr_t cfg_addr = '0;
    cfg_pkg::reg_data_t cfg_wdata = '0;
    cfg_pkg::reg_data_t cfg_rdata;
    logic cfg_rdata_valid;
    queue_pkg::flit_data_t rx_data;
    queue_pkg::flit_dest_t rx_dest;
    logic rx_last;
    logic rx_valid;
    logic rx_ready = 1'b0;
    queue_pkg::flit_data_t tx_data = '0;
    queue_pkg::flit_dest_t tx_dest = '0;
    logic tx_last = 1'b0;
    logic tx_valid = 1'b0;
    logic tx_ready;
    logic mem_req_valid;
    logic mem_req_ready;
    logic mem_req_write;
    queue_pkg::addr_t mem_req_addr;
    queue_pkg::mem_word_t mem_req_wdata;
    logic mem_req_tag;
    logic mem_rsp_valid;
    logic mem_rsp_tag;
    queue_pkg::mem_word_t mem_rsp_rdata;

    integer seed = 78;
    queue_pkg::flit_data_t flit_data [16];
    queue_pkg::flit_dest_t flit_dest [16];
    logic flit_last [16];
    queue_pkg::mem_word_t rx_expect[$];
    int rx_count = 0;

    fpga_queues #(.NUM_RX_QUEUES(1), .NUM_TX_QUEUES(1)) dut (.*);
    tb_mem_model #(.TAG_WIDTH(1)) mem_model (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        rx_ready <= !rst && (($random(seed) & 3) != 0);
    end

    // expected ring slot contents for one flit.
    function automatic queue_pkg::mem_word_t expect_word(
        input queue_pkg::flit_data_t data,
        input queue_pkg::flit_dest_t dest,
        input logic last
    );
        queue_pkg::mem_word_t word;
        word = queue_pkg::mem_word_t'(data);
        word = word | (queue_pkg::mem_word_t'(dest) << 64);
        word = word | (queue_pkg::mem_word_t'(last) << 80);
        return word;
    endfunction

    function automatic int ring_index(input int base, input int k);
        return base + k % CAP;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // transfer at the next edge when valid and ready are both high here.
    always @(negedge clk) begin
        if (!rst && rx_valid && rx_ready) begin
            if (rx_expect.size() == 0) begin
                fail_run("rx stream delivered a flit that was never queued");
            end else begin
                check($sformatf("rx flit %0d", rx_count), rx_expect.pop_front(),
                      expect_word(rx_data, rx_dest, rx_last));
                rx_count++;
            end
        end
    end

    task automatic reg_write(input int q, input logic [2:0] r, input logic [31:0] value);
        @(posedge clk);
        cfg_wr <= 1'b1;
        cfg_addr <= {q[4:0], r};
        cfg_wdata <= value;
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic reg_read(input int q, input logic [2:0] r, output logic [31:0] value);
        @(posedge clk);
        cfg_rd <= 1'b1;
        cfg_addr <= {q[4:0], r};
        @(posedge clk);
        cfg_rd <= 1'b0;
        @(negedge clk);
        check("cfg read valid", 1, cfg_rdata_valid); // one cycle after cfg_rd.
        value = cfg_rdata;
    endtask

    task automatic reg_expect(input string name, input int q, input logic [2:0] r,
                              input logic [31:0] expected);
        logic [31:0] value;
        reg_read(q, r, value);
        check(name, expected, value);
    endtask

    task automatic wait_dev_ptr(input int q, input int expected);
        logic [31:0] value;
        int tries;
        tries = 0;
        reg_read(q, cfg_pkg::REG_DEV_PTR, value);
        while (value != expected) begin
            tries++;
            if (tries > TIMEOUT) begin
                fail_run($sformatf("queue %0d device pointer never reached %0d", q, expected));
            end
            reg_read(q, cfg_pkg::REG_DEV_PTR, value);
        end
    endtask

    task automatic wait_rx(input int total);
        int cycles;
        cycles = 0;
        while (rx_count < total) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("rx stream stalled after %0d of %0d flits", rx_count, total));
            end
        end
    endtask

    task automatic new_flits(input int n);
        for (int j = 0; j < n; j++) begin
            flit_data[j] = {$random(seed), $random(seed)};
            flit_dest[j] = 16'($random(seed));
            flit_last[j] = 1'($random(seed));
        end
    endtask

    task automatic offer_tx(input int k);
        @(posedge clk);
        tx_data <= flit_data[k];
        tx_dest <= flit_dest[k];
        tx_last <= flit_last[k];
        tx_valid <= 1'b1;
    endtask

    task automatic accept_tx();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("tx_ready never rose for an offered flit");
            end
        end while (!tx_ready);
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    task automatic send_tx(input int k);
        offer_tx(k);
        accept_tx();
    endtask

    // fixed window, both streams must stay silent.
    task automatic expect_quiet(input string name, input int cycles);
        for (int j = 0; j < cycles; j++) begin
            @(negedge clk);
            check({name, " tx_ready"}, 0, tx_ready);
            check({name, " rx_valid"}, 0, rx_valid);
        end
    endtask

    task automatic check_tx_slots(input int first, input int last_k);
        for (int k = first; k <= last_k; k++) begin
            check($sformatf("tx slot for flit %0d", k),
                  expect_word(flit_data[k], flit_dest[k], flit_last[k]),
                  mem_model.mem[ring_index(TX_BASE, k)]);
        end
    endtask

    task automatic preload_rx(input int first, input int n);
        new_flits(n);
        for (int j = 0; j < n; j++) begin
            mem_model.mem[ring_index(RX_BASE, first + j)] =
                expect_word(flit_data[j], flit_dest[j], flit_last[j]);
            rx_expect.push_back(expect_word(flit_data[j], flit_dest[j], flit_last[j]));
        end
    endtask

    initial begin
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // register readback.
        reg_write(TX_Q, cfg_pkg::REG_BASE, TX_BASE);
        reg_write(TX_Q, cfg_pkg::REG_CAPACITY, CAP);
        reg_write(TX_Q, cfg_pkg::REG_HOST_PTR, 0);
        reg_write(TX_Q, cfg_pkg::REG_CTRL, CTRL_ON);
        reg_write(RX_Q, cfg_pkg::REG_BASE, RX_BASE);
        reg_write(RX_Q, cfg_pkg::REG_CAPACITY, CAP);
        reg_write(RX_Q, cfg_pkg::REG_HOST_PTR, 5);
        reg_expect("tx base", TX_Q, cfg_pkg::REG_BASE, TX_BASE);
        reg_expect("tx capacity", TX_Q, cfg_pkg::REG_CAPACITY, CAP);
        reg_expect("tx ctrl", TX_Q, cfg_pkg::REG_CTRL, CTRL_ON);
        reg_expect("tx host ptr", TX_Q, cfg_pkg::REG_HOST_PTR, 0);
        reg_expect("rx base", RX_Q, cfg_pkg::REG_BASE, RX_BASE);
        reg_expect("rx host ptr", RX_Q, cfg_pkg::REG_HOST_PTR, 5);
        reg_expect("rx ctrl", RX_Q, cfg_pkg::REG_CTRL, 0);
        reg_expect("rx dev ptr", RX_Q, cfg_pkg::REG_DEV_PTR, 0);
        reg_expect("tx dev ptr", TX_Q, cfg_pkg::REG_DEV_PTR, 0);
        reg_expect("tx status", TX_Q, cfg_pkg::REG_STATUS, 1);
        reg_expect("unmapped queue", 7, cfg_pkg::REG_BASE, 0);
        reg_expect("unmapped offset", TX_Q, 3'd7, 0);

        // tx writes into the ring.
        new_flits(5);
        for (int k = 0; k < 5; k++) begin
            send_tx(k);
        end
        wait_dev_ptr(TX_Q, 5);
        check_tx_slots(0, 4);

        // queue reset, then fill the ring until full.
        reg_write(TX_Q, cfg_pkg::REG_CTRL, CTRL_RESET);
        reg_expect("tx dev ptr after queue reset", TX_Q, cfg_pkg::REG_DEV_PTR, 0);
        new_flits(10);
        for (int k = 0; k < 7; k++) begin
            send_tx(k);
        end
        offer_tx(7);
        expect_quiet("ring full", 60);
        reg_write(TX_Q, cfg_pkg::REG_HOST_PTR, 3);
        accept_tx();
        send_tx(8);
        send_tx(9);
        wait_dev_ptr(TX_Q, ring_index(0, 10));
        check_tx_slots(2, 9);

        // both queues disabled.
        preload_rx(0, 6);
        reg_write(RX_Q, cfg_pkg::REG_HOST_PTR, 6);
        reg_write(TX_Q, cfg_pkg::REG_HOST_PTR, 0); // tx ring has room again.
        reg_write(TX_Q, cfg_pkg::REG_CTRL, 0);
        new_flits(1);
        offer_tx(0);
        expect_quiet("disabled", 40);
        reg_write(TX_Q, cfg_pkg::REG_CTRL, CTRL_ON);
        accept_tx();
        wait_dev_ptr(TX_Q, 3);
        check("tx slot after enable", expect_word(flit_data[0], flit_dest[0], flit_last[0]),
              mem_model.mem[ring_index(TX_BASE, 2)]);

        // rx reads out of the ring.
        reg_write(RX_Q, cfg_pkg::REG_CTRL, CTRL_ON);
        wait_rx(6);
        reg_expect("rx dev ptr after reads", RX_Q, cfg_pkg::REG_DEV_PTR, 6);

        // rx and tx together, rx wraps around the ring.
        preload_rx(6, 5);
        reg_write(TX_Q, cfg_pkg::REG_CTRL, CTRL_RESET);
        new_flits(6);
        fork
            begin
                for (int k = 0; k < 6; k++) begin
                    send_tx(k);
                end
            end
            begin
                reg_write(RX_Q, cfg_pkg::REG_HOST_PTR, ring_index(0, 11));
                wait_rx(11);
            end
        join
        wait_dev_ptr(TX_Q, 6);
        check_tx_slots(0, 5);
        reg_expect("rx dev ptr after wrap", RX_Q, cfg_pkg::REG_DEV_PTR, ring_index(0, 11));
        check("rx flits left over", 0, rx_expect.size());

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== tb.f ====
design/queue_pkg.sv
design/cfg_pkg.sv
design/cfg_regs.sv
design/tx_queue.sv
design/rx_queue.sv
design/mem_arbiter.sv
design/fpga_queues.sv
tests/tb_mem_model.sv
tests/tb_fpga_queues.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpga_queues -f tb.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -qF '*** PASSED ***' sim.log
echo "simulation run passed"
